// ==== hdl/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    localparam int ROB_DEPTH  = 8;
    localparam int ROB_IDX_W  = 3;
    localparam int ROB_PTR_W  = ROB_IDX_W + 1;  // extra wrap bit
    localparam int WORD_W     = 32;
    localparam int PC_W       = 32;
    localparam int GPR_ADDR_W = 5;
    localparam int EXP_W      = 4;
    localparam int NUM_WB     = 3;  // 0 alu, 1 mul, 2 load

    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [ROB_PTR_W-1:0]  rob_ptr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [GPR_ADDR_W-1:0] gpr_addr_t;
    typedef logic [EXP_W-1:0]      exp_code_t;

    localparam exp_code_t EXP_NONE = 4'd0;

    // decoder side, one per allocation
    typedef struct packed {
        pc_t       pc;
        gpr_addr_t dst_addr;
        logic      dst_wen;
        exp_code_t exp_code;
    } alloc_req_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t tag;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic     finish;
        logic     taken;
        pc_t      target;
        rob_idx_t tag;
        logic     link_valid;   // jal/jalr rd = pc+4
        word_t    link_data;
    } br_wb_t;

    typedef struct packed {
        logic      valid;
        rob_idx_t  tag;
        pc_t       pc;
        logic      dst_en;
        gpr_addr_t dst_addr;
        word_t     dst_value;
        logic      br_taken;
        pc_t       br_target;
        logic      exp_en;
        exp_code_t exp_code;
    } commit_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t tag;
    } src_req_t;

    typedef struct packed {
        logic  valid;
        word_t value;
    } src_resp_t;

    typedef struct packed {
        word_t     dst_value;
        logic      value_ready;
        logic      br_ready;
        logic      br_taken;
        pc_t       br_target;
        logic      exp_en;
        exp_code_t exp_code;
        pc_t       pc;
        gpr_addr_t dst_addr;
        logic      dst_wen;
    } entry_view_t;

    // same-cycle result for one tag, alu > mul > load > branch link
    function automatic src_resp_t wb_bypass(
        input wb_t [NUM_WB-1:0] wb,
        input br_wb_t           br_wb,
        input rob_idx_t         tag
    );
        src_resp_t r;
        r = '{valid: 1'b0, value: '0};
        if (br_wb.link_valid && br_wb.tag == tag) begin
            r = '{valid: 1'b1, value: br_wb.link_data};
        end
        for (int p = NUM_WB - 1; p >= 0; p--) begin   // walk down so port 0 wins
            if (wb[p].valid && wb[p].tag == tag) begin
                r = '{valid: 1'b1, value: wb[p].data};
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/rob_ptr_ctrl.sv ====
`default_nettype none

module rob_ptr_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_en,
    input  logic              retire,
    input  logic              flush,
    output rob_pkg::rob_idx_t head,
    output rob_pkg::rob_idx_t tail,
    output logic              rob_full,
    output logic              rob_empty
);

    rob_pkg::rob_ptr_t head_ptr;
    rob_pkg::rob_ptr_t tail_ptr;
    rob_pkg::rob_ptr_t head_inc;
    rob_pkg::rob_ptr_t head_next;
    rob_pkg::rob_ptr_t tail_next;

    assign head_inc = head_ptr + 1'b1;

    always_comb begin
        head_next = head_ptr;
        tail_next = tail_ptr;
        if (retire || flush) begin
            head_next = head_inc;
        end
        // flushing entry retires, everything younger is dropped
        if (flush) begin
            tail_next = head_inc;
        end else if (alloc_en) begin
            tail_next = tail_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            head_ptr <= head_next;
            tail_ptr <= tail_next;
        end
    end

    assign head = head_ptr[rob_pkg::ROB_IDX_W-1:0];
    assign tail = tail_ptr[rob_pkg::ROB_IDX_W-1:0];

    assign rob_empty = (head_ptr == tail_ptr);
    assign rob_full  = (head_ptr[rob_pkg::ROB_IDX_W] != tail_ptr[rob_pkg::ROB_IDX_W]) &&
                       (head == tail);   // same slot, one lap apart

    // decoder has no backpressure, it must stall on rob_full itself
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_en |-> !rob_full
    ) else $error("allocation while reorder buffer is full");

endmodule

`default_nettype wire

// ==== hdl/rob_entry_table.sv ====
`default_nettype none

module rob_entry_table (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 alloc_en,
    input  rob_pkg::alloc_req_t                  alloc_req,
    input  rob_pkg::rob_idx_t                    tail,
    input  rob_pkg::rob_idx_t                    head,
    input  rob_pkg::wb_t [rob_pkg::NUM_WB-1:0]   wb,
    input  rob_pkg::br_wb_t                      br_wb,
    input  logic                                 retire,
    input  logic                                 flush,
    input  rob_pkg::rob_idx_t                    src1_tag,
    input  rob_pkg::rob_idx_t                    src2_tag,
    output rob_pkg::entry_view_t                 head_entry,
    output rob_pkg::entry_view_t                 src1_entry,
    output rob_pkg::entry_view_t                 src2_entry
);

    // control flags
    logic [rob_pkg::ROB_DEPTH-1:0] value_ready_q;
    logic [rob_pkg::ROB_DEPTH-1:0] br_ready_q;
    logic [rob_pkg::ROB_DEPTH-1:0] br_taken_q;
    logic [rob_pkg::ROB_DEPTH-1:0] exp_en_q;

    // payload
    rob_pkg::alloc_req_t  alloc_q     [rob_pkg::ROB_DEPTH];
    rob_pkg::word_t       dst_value_q [rob_pkg::ROB_DEPTH];
    rob_pkg::pc_t         br_target_q [rob_pkg::ROB_DEPTH];

    rob_pkg::src_resp_t   wb_sel      [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::ROB_DEPTH-1:0] br_hit;
    rob_pkg::entry_view_t view        [rob_pkg::ROB_DEPTH];
    logic                 wb_conflict;

    always_comb begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            wb_sel[i] = rob_pkg::wb_bypass(wb, br_wb, rob_pkg::rob_idx_t'(i));
            br_hit[i] = br_wb.finish && (br_wb.tag == rob_pkg::rob_idx_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_ready_q <= '0;
            br_ready_q    <= '0;
            br_taken_q    <= '0;
            exp_en_q      <= '0;
        end else if (flush) begin
            value_ready_q <= '0;
            br_ready_q    <= '0;
            br_taken_q    <= '0;
            exp_en_q      <= '0;
        end else begin
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                if (retire && head == rob_pkg::rob_idx_t'(i)) begin
                    value_ready_q[i] <= 1'b0;
                    br_ready_q[i]    <= 1'b0;
                    br_taken_q[i]    <= 1'b0;
                    exp_en_q[i]      <= 1'b0;
                end
                if (alloc_en && tail == rob_pkg::rob_idx_t'(i)) begin
                    value_ready_q[i] <= 1'b0;
                    br_ready_q[i]    <= 1'b0;
                    br_taken_q[i]    <= 1'b0;
                    exp_en_q[i]      <= (alloc_req.exp_code != rob_pkg::EXP_NONE);
                end
                if (wb_sel[i].valid) begin
                    value_ready_q[i] <= 1'b1;
                end
                if (br_hit[i]) begin
                    br_ready_q[i] <= 1'b1;
                    br_taken_q[i] <= br_wb.taken;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            if (alloc_en && tail == rob_pkg::rob_idx_t'(i)) begin
                alloc_q[i] <= alloc_req;
            end
            if (wb_sel[i].valid) begin
                dst_value_q[i] <= wb_sel[i].value;
            end
            if (br_hit[i] && br_wb.taken) begin
                br_target_q[i] <= br_wb.target;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            view[i] = '{
                dst_value:   dst_value_q[i],
                value_ready: value_ready_q[i],
                br_ready:    br_ready_q[i],
                br_taken:    br_taken_q[i],
                br_target:   br_target_q[i],
                exp_en:      exp_en_q[i],
                exp_code:    alloc_q[i].exp_code,
                pc:          alloc_q[i].pc,
                dst_addr:    alloc_q[i].dst_addr,
                dst_wen:     alloc_q[i].dst_wen
            };
        end
    end

    assign head_entry = view[head];
    assign src1_entry = view[src1_tag];
    assign src2_entry = view[src2_tag];

    always_comb begin
        wb_conflict = 1'b0;
        for (int a = 0; a < rob_pkg::NUM_WB; a++) begin
            for (int b = a + 1; b < rob_pkg::NUM_WB; b++) begin
                if (wb[a].valid && wb[b].valid && wb[a].tag == wb[b].tag) begin
                    wb_conflict = 1'b1;
                end
            end
        end
    end

    // issue logic owns each tag on exactly one execution port
    a_wb_one_port_per_tag: assert property (
        @(posedge clk) disable iff (!rst_n)
        !wb_conflict
    ) else $error("two execution ports wrote the same tag");

endmodule

`default_nettype wire

// ==== hdl/rob_commit_unit.sv ====
`default_nettype none

module rob_commit_unit (
    input  rob_pkg::rob_idx_t    head,
    input  rob_pkg::entry_view_t head_entry,
    input  logic                 rob_empty,
    output rob_pkg::commit_t     commit,
    output logic                 retire,
    output logic                 flush
);

    logic complete;

    // any one of these finishes an instruction
    assign complete = head_entry.value_ready ||
                      head_entry.br_ready    ||
                      head_entry.exp_en;

    assign retire = complete && !rob_empty;
    assign flush  = retire && (head_entry.br_taken || head_entry.exp_en);

    always_comb begin
        commit.valid     = retire;
        commit.tag       = head;
        commit.pc        = head_entry.pc;
        commit.dst_en    = head_entry.value_ready && head_entry.dst_wen;
        commit.dst_addr  = head_entry.dst_addr;
        commit.dst_value = head_entry.dst_value;
        commit.br_taken  = head_entry.br_taken;   // redirect fetch
        commit.br_target = head_entry.br_target;
        commit.exp_en    = head_entry.exp_en;
        commit.exp_code  = head_entry.exp_code;
    end

endmodule

`default_nettype wire

// ==== hdl/rob_operand_read.sv ====
`default_nettype none

module rob_operand_read (
    input  logic                               clk,
    input  logic                               rst_n,
    input  rob_pkg::src_req_t                  req,
    input  rob_pkg::entry_view_t               entry,
    input  rob_pkg::wb_t [rob_pkg::NUM_WB-1:0] wb,
    input  rob_pkg::br_wb_t                    br_wb,
    output rob_pkg::src_resp_t                 resp
);

    rob_pkg::src_resp_t bypass;
    logic               hit;
    logic               valid_q;
    rob_pkg::word_t     value_q;

    // result landing this cycle beats the stored copy
    assign bypass = rob_pkg::wb_bypass(wb, br_wb, req.tag);
    assign hit    = bypass.valid || entry.value_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid && hit;   // miss means operand still in flight
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            value_q <= bypass.valid ? bypass.value : entry.dst_value;
        end
    end

    assign resp = '{valid: valid_q, value: value_q};

endmodule

`default_nettype wire

// ==== hdl/rob_top.sv ====
`default_nettype none

module rob_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               alloc_en,
    input  rob_pkg::alloc_req_t                alloc_req,
    input  rob_pkg::wb_t [rob_pkg::NUM_WB-1:0] wb,
    input  rob_pkg::br_wb_t                    br_wb,
    input  rob_pkg::src_req_t                  src1_req,
    input  rob_pkg::src_req_t                  src2_req,
    output rob_pkg::rob_idx_t                  alloc_tag,
    output logic                               rob_full,
    output logic                               rob_empty,
    output rob_pkg::commit_t                   commit,
    output rob_pkg::src_resp_t                 src1_resp,
    output rob_pkg::src_resp_t                 src2_resp
);

    rob_pkg::rob_idx_t    head;
    logic                 retire;
    logic                 flush;
    rob_pkg::entry_view_t head_entry;
    rob_pkg::entry_view_t src1_entry;
    rob_pkg::entry_view_t src2_entry;

    rob_ptr_ctrl u_ptr (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc_en  (alloc_en),
        .retire    (retire),
        .flush     (flush),
        .head      (head),
        .tail      (alloc_tag),   // tail index is the tag handed out
        .rob_full  (rob_full),
        .rob_empty (rob_empty)
    );

    rob_entry_table u_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_en   (alloc_en),
        .alloc_req  (alloc_req),
        .tail       (alloc_tag),
        .head       (head),
        .wb         (wb),
        .br_wb      (br_wb),
        .retire     (retire),
        .flush      (flush),
        .src1_tag   (src1_req.tag),
        .src2_tag   (src2_req.tag),
        .head_entry (head_entry),
        .src1_entry (src1_entry),
        .src2_entry (src2_entry)
    );

    rob_commit_unit u_commit (
        .head       (head),
        .head_entry (head_entry),
        .rob_empty  (rob_empty),
        .commit     (commit),
        .retire     (retire),
        .flush      (flush)
    );

    rob_operand_read u_src1 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (src1_req),
        .entry (src1_entry),
        .wb    (wb),
        .br_wb (br_wb),
        .resp  (src1_resp)
    );

    rob_operand_read u_src2 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (src2_req),
        .entry (src2_entry),
        .wb    (wb),
        .br_wb (br_wb),
        .resp  (src2_resp)
    );

endmodule

`default_nettype wire

// ==== verification/rob_tb.sv ====
`default_nettype none

module rob_tb;

    typedef enum logic [2:0] {OP_IDLE, OP_ALLOC, OP_WB, OP_BR, OP_SRC, OP_WB_SRC} op_t;

    // flag is dst_wen for an allocation and taken for a branch
    typedef struct packed {
        op_t                op;
        rob_pkg::rob_idx_t  tag;
        logic [1:0]         port;
        logic               flag;
        logic               link;
        rob_pkg::exp_code_t code;
        rob_pkg::rob_idx_t  tag2;     // second source tag
    } row_t;

    typedef struct packed {
        rob_pkg::pc_t       pc;
        rob_pkg::gpr_addr_t addr;
        logic               wen;
        rob_pkg::exp_code_t code;
        rob_pkg::word_t     value;
        logic               vrdy;
        logic               brdy;
        logic               taken;
        rob_pkg::pc_t       target;
    } slot_t;

    logic                               clk;
    logic                               rst_n;
    logic                               alloc_en;
    rob_pkg::alloc_req_t                alloc_req;
    rob_pkg::wb_t [rob_pkg::NUM_WB-1:0] wb;
    rob_pkg::br_wb_t                    br_wb;
    rob_pkg::src_req_t                  src1_req;
    rob_pkg::src_req_t                  src2_req;
    rob_pkg::rob_idx_t                  alloc_tag;
    logic                               rob_full;
    logic                               rob_empty;
    rob_pkg::commit_t                   commit;
    rob_pkg::src_resp_t                 src1_resp;
    rob_pkg::src_resp_t                 src2_resp;

    row_t               rows[$];
    slot_t              model [rob_pkg::ROB_DEPTH];
    rob_pkg::rob_idx_t  order_q[$];    // allocated tags, oldest first
    rob_pkg::rob_idx_t  tail_tag = '0;
    rob_pkg::src_resp_t want1 = '0;
    rob_pkg::src_resp_t want2 = '0;
    logic [31:0]        rng = 32'h1eea_8946;
    int                 cycles = 0;
    int                 cycle_limit = 0;
    int                 commits = 0;
    int                 flushes = 0;
    logic               saw_full = 1'b0;

    rob_top rob_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run passed %0d cycles without finishing the stimulus table", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input op_t op, input rob_pkg::rob_idx_t tag = 0,
                           input logic [1:0] port = 0, input logic flag = 0,
                           input logic link = 0, input rob_pkg::exp_code_t code = 0,
                           input rob_pkg::rob_idx_t tag2 = 0);
        rows.push_back('{op: op, tag: tag, port: port, flag: flag, link: link,
                         code: code, tag2: tag2});
    endtask

    task automatic build_table();
        // four entries, written back youngest first
        for (int i = 0; i < 4; i++) add_row(OP_ALLOC, 0, 0, i != 2);
        add_row(OP_WB, 3, 2);
        add_row(OP_SRC, 3, 0, 0, 0, 0, 1);      // tag 3 ready, tag 1 still in flight
        add_row(OP_WB, 2, 1);
        add_row(OP_WB, 1, 0);
        add_row(OP_WB_SRC, 0, 0, 0, 0, 0, 2);   // tag 0 through the bypass
        repeat (5) add_row(OP_IDLE);
        // fill all eight slots
        for (int i = 0; i < 8; i++) add_row(OP_ALLOC, 0, 0, i[0]);
        add_row(OP_WB, 4, 0);
        repeat (2) add_row(OP_IDLE);
        add_row(OP_BR, 5);                      // not taken
        add_row(OP_IDLE);
        add_row(OP_WB, 7, 0);
        add_row(OP_WB, 0, 2);
        add_row(OP_BR, 6, 0, 1, 1);             // taken jal, drops 7 and 0
        repeat (2) add_row(OP_IDLE);
        add_row(OP_SRC, 7, 0, 0, 0, 0, 6);
        add_row(OP_IDLE);
        // exception behind an older entry
        add_row(OP_ALLOC, 0, 0, 1);
        add_row(OP_ALLOC, 0, 0, 1, 0, 4'h2);
        add_row(OP_WB, 7, 1);
        repeat (3) add_row(OP_IDLE);
        add_row(OP_ALLOC, 0, 0, 1);
        add_row(OP_BR, 1, 0, 0, 1);             // jalr, link value only
        repeat (3) add_row(OP_IDLE);
    endtask

    task automatic drive_row(input row_t r);
        alloc_en  = 1'b0;
        alloc_req = '0;
        wb        = '0;
        br_wb     = '0;
        src1_req  = '0;
        src2_req  = '0;
        if (r.op == OP_ALLOC) begin
            alloc_en = 1'b1;
            rng = lcg_step(rng);
            alloc_req.pc = {rng[31:2], 2'b00};
            rng = lcg_step(rng);
            alloc_req.dst_addr = rng[20:16];
            alloc_req.dst_wen  = r.flag;
            alloc_req.exp_code = r.code;
        end
        if (r.op == OP_BR) begin
            rng = lcg_step(rng);
            br_wb.finish     = 1'b1;
            br_wb.taken      = r.flag;
            br_wb.target     = {rng[31:2], 2'b00};
            br_wb.tag        = r.tag;
            br_wb.link_valid = r.link;
            br_wb.link_data  = model[r.tag].pc + 32'd4;   // rd = pc + 4
        end
        if (r.op == OP_WB || r.op == OP_WB_SRC) begin
            rng = lcg_step(rng);
            wb[r.port].valid = 1'b1;
            wb[r.port].tag   = r.tag;
            wb[r.port].data  = rng;
        end
        if (r.op == OP_SRC || r.op == OP_WB_SRC) begin
            src1_req = '{valid: 1'b1, tag: r.tag};
            src2_req = '{valid: 1'b1, tag: r.tag2};
        end
    endtask

    function automatic logic head_done(input rob_pkg::rob_idx_t t);
        return model[t].vrdy || model[t].brdy || model[t].code != rob_pkg::EXP_NONE;
    endfunction

    // response due one cycle after the request
    function automatic rob_pkg::src_resp_t expect_src(input rob_pkg::src_req_t req);
        rob_pkg::src_resp_t r;
        r = '0;
        if (req.valid) begin
            for (int p = 0; p < rob_pkg::NUM_WB; p++) begin
                if (!r.valid && wb[p].valid && wb[p].tag == req.tag) begin
                    r = '{valid: 1'b1, value: wb[p].data};
                end
            end
            if (!r.valid && br_wb.link_valid && br_wb.tag == req.tag) begin
                r = '{valid: 1'b1, value: br_wb.link_data};
            end
            if (!r.valid && model[req.tag].vrdy) begin
                r = '{valid: 1'b1, value: model[req.tag].value};
            end
        end
        return r;
    endfunction

    task automatic compare_outputs();
        rob_pkg::rob_idx_t t;
        logic              due;
        due = order_q.size() > 0 && head_done(order_q[0]);
        check("commit.valid", 32'(commit.valid), 32'(due));
        if (due) begin
            t = order_q[0];
            commits++;
            check("commit.tag", 32'(commit.tag), 32'(t));
            check("commit.pc", commit.pc, model[t].pc);
            check("commit.dst_en", 32'(commit.dst_en), 32'(model[t].vrdy && model[t].wen));
            check("commit.dst_addr", 32'(commit.dst_addr), 32'(model[t].addr));
            if (model[t].vrdy) check("commit.dst_value", commit.dst_value, model[t].value);
            check("commit.br_taken", 32'(commit.br_taken), 32'(model[t].taken));
            if (model[t].taken) check("commit.br_target", commit.br_target, model[t].target);
            check("commit.exp_en", 32'(commit.exp_en), 32'(model[t].code != rob_pkg::EXP_NONE));
            check("commit.exp_code", 32'(commit.exp_code), 32'(model[t].code));
        end
        check("rob_empty", 32'(rob_empty), 32'(order_q.size() == 0));
        check("rob_full", 32'(rob_full), 32'(order_q.size() == rob_pkg::ROB_DEPTH));
        check("alloc_tag", 32'(alloc_tag), 32'(tail_tag));
        check("src1_resp.valid", 32'(src1_resp.valid), 32'(want1.valid));
        if (want1.valid) check("src1_resp.value", src1_resp.value, want1.value);
        check("src2_resp.valid", 32'(src2_resp.valid), 32'(want2.valid));
        if (want2.valid) check("src2_resp.value", src2_resp.value, want2.value);
        if (rob_full) saw_full = 1'b1;
    endtask

    // state after the coming edge, retire first
    task automatic advance_model();
        rob_pkg::rob_idx_t t;
        if (order_q.size() > 0 && head_done(order_q[0])) begin
            t = order_q.pop_front();
            if (model[t].taken || model[t].code != rob_pkg::EXP_NONE) begin
                flushes++;
                order_q.delete();
                tail_tag = t + 3'd1;
                for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                    model[i].vrdy  = 1'b0;
                    model[i].brdy  = 1'b0;
                    model[i].taken = 1'b0;
                end
                return;    // nothing else lands on a flush edge
            end
            model[t].vrdy  = 1'b0;
            model[t].brdy  = 1'b0;
            model[t].taken = 1'b0;
        end
        if (alloc_en) begin
            model[tail_tag] = '{pc: alloc_req.pc, addr: alloc_req.dst_addr,
                                wen: alloc_req.dst_wen, code: alloc_req.exp_code,
                                value: '0, vrdy: 1'b0, brdy: 1'b0, taken: 1'b0, target: '0};
            order_q.push_back(tail_tag);
            tail_tag = tail_tag + 3'd1;
        end
        if (br_wb.finish) begin
            model[br_wb.tag].brdy  = 1'b1;
            model[br_wb.tag].taken = br_wb.taken;
            if (br_wb.taken) model[br_wb.tag].target = br_wb.target;
        end
        if (br_wb.link_valid) begin
            model[br_wb.tag].vrdy  = 1'b1;
            model[br_wb.tag].value = br_wb.link_data;
        end
        for (int p = 0; p < rob_pkg::NUM_WB; p++) begin
            if (wb[p].valid) begin
                model[wb[p].tag].vrdy  = 1'b1;
                model[wb[p].tag].value = wb[p].data;
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        alloc_en  = 1'b0;
        alloc_req = '0;
        wb        = '0;
        br_wb     = '0;
        src1_req  = '0;
        src2_req  = '0;
        foreach (model[i]) model[i] = '0;
        build_table();
        cycle_limit = rows.size() * 20;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("rob_empty", 32'(rob_empty), 32'd1);
        check("rob_full", 32'(rob_full), 32'd0);
        check("commit.valid", 32'(commit.valid), 32'd0);
        check("alloc_tag", 32'(alloc_tag), 32'd0);
        foreach (rows[i]) begin
            compare_outputs();
            drive_row(rows[i]);
            want1 = expect_src(src1_req);
            want2 = expect_src(src2_req);
            advance_model();
            @(negedge clk);
        end
        compare_outputs();
        // 4 in order, 3 around the full buffer, 3 in the exception run
        check("commit count", 32'(commits), 32'd10);
        check("flush count", 32'(flushes), 32'd2);
        check("rob_full seen", 32'(saw_full), 32'd1);
        check("rob_empty", 32'(rob_empty), 32'd1);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/rob_pkg.sv
hdl/rob_ptr_ctrl.sv
hdl/rob_entry_table.sv
hdl/rob_commit_unit.sv
hdl/rob_operand_read.sv
hdl/rob_top.sv
verification/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module rob_tb -o rob_sim
out=$(./obj_dir/rob_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q '^TEST OK$'; then
    exit 0
fi
exit 1
